/* rv_pkg.sv */
package rv_pkg;

    // base integer width, pc and data
    parameter int XLEN = 64;

    // base instruction width, no compressed forms
    parameter int ILEN = 32;

    typedef logic [XLEN-1:0] xword_t;
    typedef logic [ILEN-1:0] inst_t;

    // start of the boot image in the address map
    parameter xword_t DEFAULT_RESET_PC = 64'h0000_0000_8000_0000;

endpackage

/* bus_pkg.sv */
package bus_pkg;

    // read bus address width
    parameter int ADDR_W = 64;

    // size code is a byte-lane mask over the 64-bit data word
    // low four lanes set means a 4-byte read
    parameter logic [7:0] RD_SIZE_WORD = 8'b0000_1111;

    // cycles from address acceptance to valid data
    parameter int DEFAULT_MEM_LATENCY = 2;

endpackage

/* redirect_unit.sv */
`timescale 1ns/1ps

module redirect_unit (
    // control from the memory stage
    input  logic           me_jal_i,
    input  logic           me_jalr_i,
    input  logic           me_branch_i,
    input  rv_pkg::xword_t me_alu_res_i,
    input  rv_pkg::xword_t me_pc_i,
    input  rv_pkg::xword_t me_imm_i,
    input  rv_pkg::xword_t me_rs1_i,
    // trap request and its vector
    input  logic           trap_i,
    input  rv_pkg::xword_t trap_vec_i,
    // resolved redirect
    output logic           redirect_o,
    output rv_pkg::xword_t target_o
);
    import rv_pkg::*;

    xword_t pc_rel_target;
    xword_t reg_rel_sum;
    xword_t reg_rel_target;
    logic   branch_taken;
    logic   take_pc_rel;

    // jal and branches are relative to the pc of the instruction
    assign pc_rel_target = me_pc_i + me_imm_i;

    // jalr drops bit 0 of the sum
    assign reg_rel_sum    = me_rs1_i + me_imm_i;
    assign reg_rel_target = {reg_rel_sum[XLEN-1:1], 1'b0};

    // comparison is done in the ALU, a zero result means taken
    assign branch_taken = me_branch_i && (me_alu_res_i == '0);
    assign take_pc_rel  = me_jal_i || branch_taken;

    // fixed priority, pc-relative first, trap last
    always_comb begin
        redirect_o = 1'b1;
        if (take_pc_rel) begin
            target_o = pc_rel_target;
        end else if (me_jalr_i) begin
            target_o = reg_rel_target;
        end else if (trap_i) begin
            target_o = trap_vec_i;
        end else begin
            redirect_o = 1'b0;
            target_o   = '0;
        end
    end

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter rv_pkg::xword_t RESET_PC = rv_pkg::DEFAULT_RESET_PC
) (
    input  logic                       clk,
    input  logic                       reset_i,
    // redirect, already resolved
    input  logic                       redirect_i,
    input  rv_pkg::xword_t             target_i,
    // read bus, address channel
    output logic                       rd_addr_valid_o,
    output logic [bus_pkg::ADDR_W-1:0] rd_addr_o,
    output logic [7:0]                 rd_size_o,
    input  logic                       rd_addr_ready_i,
    // read bus, data channel
    input  logic                       rd_data_valid_i,
    input  rv_pkg::xword_t             rd_data_i,
    output logic                       rd_data_ready_o,
    // instruction stream out
    output logic                       inst_valid_o,
    input  logic                       inst_ready_i,
    output rv_pkg::inst_t              inst_o,
    output rv_pkg::xword_t             pc_o
);
    import rv_pkg::*;
    import bus_pkg::*;

    // IDLE  nothing in flight, output empty
    // ADDR  address offered on the bus
    // DATA  waiting for the response
    // HOLD  output register full
    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_HOLD
    } state_t;

    state_t            state;
    xword_t            pc;
    logic              epoch;
    logic              req_epoch;
    logic [ADDR_W-1:0] req_addr;
    inst_t             inst_q;
    xword_t            pc_q;

    xword_t            pc_eff;
    logic              epoch_eff;
    logic              issue;
    logic              data_fire;
    logic              stale;
    logic              deliver;

    // a redirect in this cycle is already visible to a new request
    assign pc_eff    = redirect_i ? target_i : pc;
    assign epoch_eff = epoch ^ redirect_i;

    // only issue once the output slot is empty or draining
    always_comb begin
        case (state)
            S_IDLE:  issue = 1'b1;
            S_HOLD:  issue = inst_ready_i || redirect_i;
            default: issue = 1'b0;
        endcase
    end

    assign data_fire = (state == S_DATA) && rd_data_valid_i;

    // response belongs to an older stream, or is overtaken right now
    assign stale   = (req_epoch != epoch) || redirect_i;
    assign deliver = data_fire && !stale;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE, S_HOLD: begin
                    if (issue) begin
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (rd_addr_ready_i) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (rd_data_valid_i) begin
                        // a discarded word leaves the output empty
                        state <= stale ? S_IDLE : S_HOLD;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // pc is the next address to fetch
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc        <= RESET_PC;
            epoch     <= 1'b0;
            req_epoch <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc    <= target_i;
                epoch <= ~epoch;
            end else if (deliver) begin
                pc <= pc + XLEN'(4);
            end
            if (issue) begin
                req_epoch <= epoch_eff;
            end
        end
    end

    // address stays put until accepted, issue only happens outside ADDR
    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr <= pc_eff;
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (deliver) begin
            inst_q <= rd_data_i[ILEN-1:0];
            pc_q   <= req_addr;
        end
    end

    assign rd_addr_valid_o = (state == S_ADDR);
    assign rd_addr_o       = req_addr;
    assign rd_size_o       = RD_SIZE_WORD;
    assign rd_data_ready_o = (state == S_DATA);

    assign inst_valid_o = (state == S_HOLD);
    assign inst_o       = inst_q;
    assign pc_o         = pc_q;

endmodule

/* inst_sram.sv */
`timescale 1ns/1ps

module inst_sram #(
    parameter int MEM_WORDS = 1024,
    parameter int LATENCY   = bus_pkg::DEFAULT_MEM_LATENCY
) (
    input  logic                         clk,
    input  logic                         reset_i,
    // read bus, address channel
    input  logic                         rd_addr_valid_i,
    input  logic [bus_pkg::ADDR_W-1:0]   rd_addr_i,
    input  logic [7:0]                   rd_size_i,
    output logic                         rd_addr_ready_o,
    // read bus, data channel
    output logic                         rd_data_valid_o,
    output rv_pkg::xword_t               rd_data_o,
    input  logic                         rd_data_ready_i,
    // preload port, word indexed
    input  logic                         ld_en_i,
    input  logic [$clog2(MEM_WORDS)-1:0] ld_addr_i,
    input  rv_pkg::inst_t                ld_data_i
);
    import rv_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_RESP
    } state_t;

    inst_t            mem [MEM_WORDS];

    state_t           state;
    logic [CNT_W-1:0] cnt;
    logic [IDX_W-1:0] idx_q;
    logic [7:0]       size_q;
    xword_t           data_q;

    xword_t           word_ext;
    xword_t           lane_mask;
    logic             addr_fire;

    assign addr_fire = rd_addr_valid_i && (state == S_IDLE);

    always_ff @(posedge clk) begin
        if (ld_en_i) begin
            mem[ld_addr_i] <= ld_data_i;
        end
    end

    // size bits select byte lanes of the returned word
    always_comb begin
        for (int b = 0; b < XLEN / 8; b++) begin
            lane_mask[b*8 +: 8] = {8{size_q[b]}};
        end
    end

    assign word_ext = {{(XLEN - ILEN){1'b0}}, mem[idx_q]};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (addr_fire) begin
                        state <= S_WAIT;
                        cnt   <= CNT_W'(LATENCY - 1);
                    end
                end
                S_WAIT: begin
                    if (cnt == '0) begin
                        state <= S_RESP;
                    end else begin
                        cnt <= cnt - CNT_W'(1);
                    end
                end
                S_RESP: begin
                    if (rd_data_ready_i) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // request capture and read data
    always_ff @(posedge clk) begin
        if (addr_fire) begin
            // byte address to word index, wraps at MEM_WORDS
            idx_q  <= rd_addr_i[IDX_W+1:2];
            size_q <= rd_size_i;
        end
        if ((state == S_WAIT) && (cnt == '0)) begin
            data_q <= word_ext & lane_mask;
        end
    end

    assign rd_addr_ready_o = (state == S_IDLE);
    assign rd_data_valid_o = (state == S_RESP);
    assign rd_data_o       = data_q;

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
    parameter rv_pkg::xword_t RESET_PC    = rv_pkg::DEFAULT_RESET_PC,
    parameter int             MEM_WORDS   = 1024,
    parameter int             MEM_LATENCY = bus_pkg::DEFAULT_MEM_LATENCY
) (
    input  logic                         clk,
    input  logic                         reset_i,
    // memory stage redirect sources
    input  logic                         me_jal_i,
    input  logic                         me_jalr_i,
    input  logic                         me_branch_i,
    input  rv_pkg::xword_t               me_alu_res_i,
    input  rv_pkg::xword_t               me_pc_i,
    input  rv_pkg::xword_t               me_imm_i,
    input  rv_pkg::xword_t               me_rs1_i,
    input  logic                         trap_i,
    input  rv_pkg::xword_t               trap_vec_i,
    // program load
    input  logic                         ld_en_i,
    input  logic [$clog2(MEM_WORDS)-1:0] ld_addr_i,
    input  rv_pkg::inst_t                ld_data_i,
    // fetched instructions
    output logic                         inst_valid_o,
    input  logic                         inst_ready_i,
    output rv_pkg::inst_t                inst_o,
    output rv_pkg::xword_t               pc_o
);
    import rv_pkg::*;
    import bus_pkg::*;

    logic              redirect;
    xword_t            redirect_target;

    // read bus between fetch and memory
    logic              rd_addr_valid;
    logic              rd_addr_ready;
    logic [ADDR_W-1:0] rd_addr;
    logic [7:0]        rd_size;
    logic              rd_data_valid;
    logic              rd_data_ready;
    xword_t            rd_data;

    redirect_unit u_redirect (
        .me_jal_i     (me_jal_i),
        .me_jalr_i    (me_jalr_i),
        .me_branch_i  (me_branch_i),
        .me_alu_res_i (me_alu_res_i),
        .me_pc_i      (me_pc_i),
        .me_imm_i     (me_imm_i),
        .me_rs1_i     (me_rs1_i),
        .trap_i       (trap_i),
        .trap_vec_i   (trap_vec_i),
        .redirect_o   (redirect),
        .target_o     (redirect_target)
    );

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk             (clk),
        .reset_i         (reset_i),
        .redirect_i      (redirect),
        .target_i        (redirect_target),
        .rd_addr_valid_o (rd_addr_valid),
        .rd_addr_o       (rd_addr),
        .rd_size_o       (rd_size),
        .rd_addr_ready_i (rd_addr_ready),
        .rd_data_valid_i (rd_data_valid),
        .rd_data_i       (rd_data),
        .rd_data_ready_o (rd_data_ready),
        .inst_valid_o    (inst_valid_o),
        .inst_ready_i    (inst_ready_i),
        .inst_o          (inst_o),
        .pc_o            (pc_o)
    );

    inst_sram #(
        .MEM_WORDS (MEM_WORDS),
        .LATENCY   (MEM_LATENCY)
    ) u_sram (
        .clk             (clk),
        .reset_i         (reset_i),
        .rd_addr_valid_i (rd_addr_valid),
        .rd_addr_i       (rd_addr),
        .rd_size_i       (rd_size),
        .rd_addr_ready_o (rd_addr_ready),
        .rd_data_valid_o (rd_data_valid),
        .rd_data_o       (rd_data),
        .rd_data_ready_i (rd_data_ready),
        .ld_en_i         (ld_en_i),
        .ld_addr_i       (ld_addr_i),
        .ld_data_i       (ld_data_i)
    );

endmodule

/* tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;
    import rv_pkg::*;

    localparam xword_t RESET_PC  = 64'h0000_0000_8000_0000;
    localparam int     MEM_WORDS = 1024;
    localparam int     IDX_W     = 10;
    localparam int     LATENCY   = 3;

    logic             clk = 1'b0;
    logic             reset_i;
    logic             me_jal_i;
    logic             me_jalr_i;
    logic             me_branch_i;
    xword_t           me_alu_res_i;
    xword_t           me_pc_i;
    xword_t           me_imm_i;
    xword_t           me_rs1_i;
    logic             trap_i;
    xword_t           trap_vec_i;
    logic             ld_en_i;
    logic [IDX_W-1:0] ld_addr_i;
    inst_t            ld_data_i;
    logic             inst_valid_o;
    logic             inst_ready_i;
    inst_t            inst_o;
    xword_t           pc_o;

    // model state, owned by the compare process
    inst_t            shadow [MEM_WORDS];
    xword_t           exp_pc;
    xword_t           got_pc [$];
    int               n_deliv = 0;
    int               errors  = 0;
    string            test_name = "reset";
    logic [31:0]      lcg_state = 32'h8d1e_10ea;

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (LATENCY)
    ) DUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic random_bit();
        logic [31:0] r;
        r = lcg_next();
        return r[31];
    endfunction

    // expected pc after one clock edge
    function automatic xword_t next_pc(input logic jal, input logic jalr, input logic branch,
                                       input xword_t alu, input xword_t mpc, input xword_t imm,
                                       input xword_t rs1, input logic trap, input xword_t vec,
                                       input xword_t cur, input logic delivered);
        xword_t sum;
        sum = rs1 + imm;
        if (jal || (branch && (alu == 64'd0))) return mpc + imm;
        if (jalr) return sum & ~64'd1;
        if (trap) return vec;
        if (delivered) return cur + 64'd4;
        return cur;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input xword_t expected, input xword_t actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
            stop_run("stopping at the first mismatch");
        end
    endtask

    // every output transfer is checked against the model
    always @(posedge clk) begin
        logic delivered;
        delivered = inst_valid_o && inst_ready_i;
        if (reset_i) begin
            exp_pc = RESET_PC;
        end else begin
            if (delivered) begin
                check_value("pc_o", exp_pc, pc_o);
                check_value("inst_o", {32'd0, shadow[exp_pc[IDX_W+1:2]]}, {32'd0, inst_o});
                got_pc.push_back(pc_o);
                n_deliv++;
            end
            exp_pc = next_pc(me_jal_i, me_jalr_i, me_branch_i, me_alu_res_i, me_pc_i,
                             me_imm_i, me_rs1_i, trap_i, trap_vec_i, exp_pc, delivered);
        end
    end

    task automatic clear_redirect();
        me_jal_i     = 1'b0;
        me_jalr_i    = 1'b0;
        me_branch_i  = 1'b0;
        me_alu_res_i = 64'd0;
        me_pc_i      = 64'd0;
        me_imm_i     = 64'd0;
        me_rs1_i     = 64'd0;
        trap_i       = 1'b0;
        trap_vec_i   = 64'd0;
    endtask

    task automatic apply_reset();
        reset_i      = 1'b1;
        inst_ready_i = 1'b0;
        repeat (4) @(negedge clk);
        check_value("inst_valid_o in reset", 64'd0, {63'd0, inst_valid_o});
        reset_i = 1'b0;
    endtask

    // all stimulus tasks start and end on a falling edge
    task automatic run_stream(input int n, input logic random_ready);
        int target;
        int cycles;
        target = n_deliv + n;
        cycles = 0;
        while (n_deliv < target) begin
            if (cycles == n * 40 + 100) begin
                stop_run($sformatf("timeout waiting for %0d deliveries in %s", n, test_name));
            end
            inst_ready_i = random_ready ? random_bit() : 1'b1;
            @(negedge clk);
            cycles++;
        end
        inst_ready_i = 1'b0;
    endtask

    task automatic wait_for_valid();
        int cycles;
        cycles = 0;
        inst_ready_i = 1'b0;
        while (!inst_valid_o) begin
            if (cycles == 100) begin
                stop_run("timeout waiting for inst_valid_o");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // one cycle of redirect inputs, no output transfer in that cycle
    task automatic apply_redirect(input logic jal, input logic jalr, input logic branch,
                                  input xword_t alu, input xword_t mpc, input xword_t imm,
                                  input xword_t rs1, input logic trap, input xword_t vec);
        inst_ready_i = 1'b0;
        me_jal_i     = jal;
        me_jalr_i    = jalr;
        me_branch_i  = branch;
        me_alu_res_i = alu;
        me_pc_i      = mpc;
        me_imm_i     = imm;
        me_rs1_i     = rs1;
        trap_i       = trap;
        trap_vec_i   = vec;
        @(negedge clk);
        clear_redirect();
    endtask

    task automatic expect_next(input xword_t expected);
        got_pc.delete();
        run_stream(4, 1'b0);
        check_value("first pc after redirect", expected, got_pc[0]);
    endtask

    initial begin
        xword_t      seq_ref [$];
        xword_t      last_pc;
        xword_t      offset;
        xword_t      target;
        logic [31:0] r;

        reset_i      = 1'b1;
        inst_ready_i = 1'b0;
        ld_en_i      = 1'b0;
        ld_addr_i    = '0;
        ld_data_i    = '0;
        clear_redirect();

        // program preload while the fetch unit is held in reset
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(negedge clk);
            shadow[i] = lcg_next();
            ld_en_i   = 1'b1;
            ld_addr_i = IDX_W'(i);
            ld_data_i = shadow[i];
        end
        @(negedge clk);
        ld_en_i = 1'b0;
        apply_reset();

        test_name = "sequential";
        got_pc.delete();
        run_stream(50, 1'b0);
        for (int i = 0; i < 50; i++) begin
            check_value("pc step", RESET_PC + 64'(4 * i), got_pc[i]);
        end
        seq_ref = got_pc;

        test_name = "back-pressure";
        apply_reset();
        got_pc.delete();
        run_stream(50, 1'b1);
        for (int i = 0; i < 50; i++) begin
            check_value("sequence", seq_ref[i], got_pc[i]);
        end

        test_name = "jal";
        apply_redirect(1'b1, 1'b0, 1'b0, 64'd9, RESET_PC + 64'h100, 64'h40, 64'd0, 1'b0, 64'd0);
        expect_next(RESET_PC + 64'h140);
        test_name = "branch taken";
        apply_redirect(1'b0, 1'b0, 1'b1, 64'd0, RESET_PC + 64'h200, -64'sd8, 64'd0, 1'b0, 64'd0);
        expect_next(RESET_PC + 64'h1f8);
        test_name = "branch not taken";
        last_pc = got_pc[$];
        apply_redirect(1'b0, 1'b0, 1'b1, 64'd1, RESET_PC, 64'h40, 64'd0, 1'b0, 64'd0);
        expect_next(last_pc + 64'd4);
        test_name = "jalr";
        apply_redirect(1'b0, 1'b1, 1'b0, 64'd0, 64'd0, 64'h10, RESET_PC + 64'h301, 1'b0, 64'd0);
        expect_next(RESET_PC + 64'h310);
        test_name = "trap";
        apply_redirect(1'b0, 1'b0, 1'b0, 64'd0, 64'd0, 64'd0, 64'd0, 1'b1, RESET_PC + 64'h380);
        expect_next(RESET_PC + 64'h380);

        // several sources at once
        test_name = "priority jal";
        apply_redirect(1'b1, 1'b1, 1'b0, 64'd3, RESET_PC, 64'h20, RESET_PC + 64'h300, 1'b1,
                       RESET_PC + 64'h380);
        expect_next(RESET_PC + 64'h20);
        test_name = "priority jalr";
        apply_redirect(1'b0, 1'b1, 1'b1, 64'd3, RESET_PC, 64'h20, RESET_PC + 64'h300, 1'b1,
                       RESET_PC + 64'h380);
        expect_next(RESET_PC + 64'h320);
        test_name = "priority trap";
        apply_redirect(1'b0, 1'b0, 1'b1, 64'd3, RESET_PC, 64'h20, 64'd0, 1'b1,
                       RESET_PC + 64'h3c0);
        expect_next(RESET_PC + 64'h3c0);

        test_name = "redirect in flight";
        run_stream(1, 1'b0);
        apply_redirect(1'b1, 1'b0, 1'b0, 64'd0, RESET_PC + 64'h80, 64'h20, 64'd0, 1'b0, 64'd0);
        expect_next(RESET_PC + 64'ha0);
        test_name = "redirect while held";
        wait_for_valid();
        apply_redirect(1'b0, 1'b0, 1'b0, 64'd0, 64'd0, 64'd0, 64'd0, 1'b1, RESET_PC + 64'h240);
        expect_next(RESET_PC + 64'h240);

        // redirect at random points of the read
        test_name = "random redirect";
        for (int k = 0; k < 20; k++) begin
            r      = lcg_next();
            offset = {54'd0, r[9:2], 2'b00};
            target = RESET_PC + offset;
            for (int c = 0; c < int'(r[14:12]); c++) begin
                inst_ready_i = random_bit();
                @(negedge clk);
            end
            case (r[17:16])
                2'd0: apply_redirect(1'b1, 1'b0, 1'b0, 64'd7, RESET_PC, offset, 64'd0, 1'b0, 64'd0);
                2'd1: apply_redirect(1'b0, 1'b0, 1'b1, 64'd0, RESET_PC, offset, 64'd0, 1'b0, 64'd0);
                2'd2: apply_redirect(1'b0, 1'b1, 1'b0, 64'd7, 64'd0, offset | 64'd1, RESET_PC,
                                     1'b0, 64'd0);
                default: apply_redirect(1'b0, 1'b0, 1'b0, 64'd7, 64'd0, 64'd0, 64'd0, 1'b1,
                                        target);
            endcase
            expect_next(target);
        end
        run_stream(20, 1'b1);

        if (errors == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_run("errors were recorded");
        end
    end

endmodule

/* flist.f */
rv_pkg.sv
bus_pkg.sv
redirect_unit.sv
fetch_unit.sv
inst_sram.sv
fetch_top.sv
tb_fetch_top.sv

/* Makefile */
# Verilator simulation of the instruction fetch block

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	rm -f $(LOG)
	verilator --binary --timing -j 0 --top-module tb_fetch_top -Mdir obj_dir -f flist.f
	./obj_dir/Vtb_fetch_top 2>&1 | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
